/* logic/cop_isa_pkg.sv */
//////////////////////////////
// Instruction encoding of the crypto co-processor
// Opcode, field positions, function codes and the
// decoded operation that the decoder hands to the ALU
//////////////////////////////

package cop_isa_pkg;

    // Custom-0 major opcode, bits 6..0 of every accepted word
    localparam logic [6:0] COP_OPCODE = 7'b0001011;

    // Low bit of each field in the instruction word
    localparam int FLD_RD_LO    = 7;    // GPR destination, 5 bits
    localparam int FLD_CRS1_LO  = 16;   // CPR source 1, 4 bits
    localparam int FLD_CRS2_LO  = 20;   // CPR source 2, 4 bits
    localparam int FLD_CRD_LO   = 24;   // CPR destination, 4 bits
    localparam int FLD_FUNCT_LO = 28;   // Function code, 4 bits

    // Function codes, bits 31..28
    // Codes 6 to 15 are reserved and decode as illegal
    typedef enum logic [3:0] {
        FN_GPR2XCR = 4'd0,  // crd <- rs1 of the CPU
        FN_XCR2GPR = 4'd1,  // rd <- crs1
        FN_AND     = 4'd2,  // crd <- crs1 & crs2
        FN_OR      = 4'd3,  // crd <- crs1 | crs2
        FN_XOR     = 4'd4,  // crd <- crs1 ^ crs2
        FN_NOT     = 4'd5   // crd <- ~crs1
    } cop_funct_e;

    // Decoded operation seen by the ALU
    // OP_NONE marks an illegal word and makes the ALU output zero
    typedef enum logic [2:0] {
        OP_GPR2XCR = 3'd0,  // Move GPR to CPR
        OP_XCR2GPR = 3'd1,  // Move CPR to GPR
        OP_AND     = 3'd2,  // Bitwise and
        OP_OR      = 3'd3,  // Bitwise or
        OP_XOR     = 3'd4,  // Bitwise xor
        OP_NOT     = 3'd5,  // Bitwise invert
        OP_NONE    = 3'd6   // Nothing to do
    } cop_op_e;

endpackage

/* logic/cop_core_pkg.sv */
//////////////////////////////
// Core-level definitions of the co-processor
// Widths, register count, result codes and the
// states of the CPU handshake
//////////////////////////////

package cop_core_pkg;

    localparam int XLEN      = 32;  // Data path width
    localparam int CPR_COUNT = 16;  // Coprocessor registers

    typedef logic [$clog2(CPR_COUNT)-1:0] cpr_addr_t;  // CPR index
    typedef logic [4:0]                   gpr_addr_t;  // CPU GPR index
    typedef logic [XLEN-1:0]              word_t;      // Data word

    // Result code returned with every response
    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0,  // Executed normally
        RES_BAD_INS = 3'd1   // Illegal opcode or function
    } cop_result_e;

    // Handshake FSM states
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,  // Just out of reset
        ST_WAITING  = 2'd1,  // Ack high, waiting for a request
        ST_FINISHED = 2'd2   // Response held until the CPU acks
    } issue_state_e;

endpackage

/* logic/cop_ifs.sv */
//////////////////////////////
// Internal interfaces of the co-processor
// cop_uop_if carries the decoded operation and
// cop_cpr_rd_if is the two-port CPR read path
//////////////////////////////

interface cop_uop_if;

    cop_isa_pkg::cop_op_e    op;          // Operation for the ALU
    cop_core_pkg::cpr_addr_t crd;         // CPR destination
    cop_core_pkg::gpr_addr_t rd;          // GPR destination
    logic                    writes_cpr;  // Instruction updates crd
    logic                    writes_gpr;  // Response carries GPR write
    logic                    illegal;     // Bad opcode or function

    modport decoder (output op, crd, rd, writes_cpr, writes_gpr, illegal);
    modport alu     (input op);
    modport issue   (input crd, rd, writes_cpr, writes_gpr, illegal);

endinterface

interface cop_cpr_rd_if;

    cop_core_pkg::cpr_addr_t crs1_addr;   // Port 1 index
    cop_core_pkg::cpr_addr_t crs2_addr;   // Port 2 index
    cop_core_pkg::word_t     crs1_rdata;  // Port 1 data, same cycle
    cop_core_pkg::word_t     crs2_rdata;  // Port 2 data, same cycle

    modport decoder (output crs1_addr, crs2_addr);
    modport regfile (input crs1_addr, crs2_addr, output crs1_rdata, crs2_rdata);
    modport alu     (input crs1_rdata, crs2_rdata);

endinterface

/* logic/cop_decode.sv */
//////////////////////////////
// Instruction decoder, purely combinational
// Checks opcode and function, flags illegal words,
// extracts register fields and drives the CPR reads
//////////////////////////////

module cop_decode (
    input  cop_core_pkg::word_t insn_enc,  // Word from the CPU
    cop_uop_if.decoder          uop,       // Decoded operation out
    cop_cpr_rd_if.decoder       rd_port    // CPR read addresses
);

    logic [$bits(cop_isa_pkg::cop_funct_e)-1:0] funct;  // Raw function field
    logic                                       opcode_ok;
    logic                                       funct_ok;
    logic                                       illegal;
    cop_isa_pkg::cop_op_e                       op_raw;  // Op before illegal mask

    assign opcode_ok = (insn_enc[$bits(cop_isa_pkg::COP_OPCODE)-1:0]
                        == cop_isa_pkg::COP_OPCODE);
    assign funct = insn_enc[cop_isa_pkg::FLD_FUNCT_LO +: $bits(cop_isa_pkg::cop_funct_e)];

    // Function code to operation
    always_comb begin
        funct_ok = 1'b1;
        op_raw   = cop_isa_pkg::OP_NONE;
        case (funct)
            cop_isa_pkg::FN_GPR2XCR: op_raw = cop_isa_pkg::OP_GPR2XCR;
            cop_isa_pkg::FN_XCR2GPR: op_raw = cop_isa_pkg::OP_XCR2GPR;
            cop_isa_pkg::FN_AND:     op_raw = cop_isa_pkg::OP_AND;
            cop_isa_pkg::FN_OR:      op_raw = cop_isa_pkg::OP_OR;
            cop_isa_pkg::FN_XOR:     op_raw = cop_isa_pkg::OP_XOR;
            cop_isa_pkg::FN_NOT:     op_raw = cop_isa_pkg::OP_NOT;
            default:                 funct_ok = 1'b0;  // Reserved 6..15
        endcase
    end

    assign illegal = !(opcode_ok && funct_ok);

    // Illegal words become OP_NONE and write nothing
    assign uop.illegal    = illegal;
    assign uop.op         = illegal ? cop_isa_pkg::OP_NONE : op_raw;
    assign uop.writes_gpr = !illegal && (op_raw == cop_isa_pkg::OP_XCR2GPR);
    assign uop.writes_cpr = !illegal && (op_raw != cop_isa_pkg::OP_XCR2GPR);

    // Register fields
    assign uop.rd  = insn_enc[cop_isa_pkg::FLD_RD_LO +: $bits(cop_core_pkg::gpr_addr_t)];
    assign uop.crd = insn_enc[cop_isa_pkg::FLD_CRD_LO +: $bits(cop_core_pkg::cpr_addr_t)];

    // Read ports always follow the source fields
    assign rd_port.crs1_addr =
        insn_enc[cop_isa_pkg::FLD_CRS1_LO +: $bits(cop_core_pkg::cpr_addr_t)];
    assign rd_port.crs2_addr =
        insn_enc[cop_isa_pkg::FLD_CRS2_LO +: $bits(cop_core_pkg::cpr_addr_t)];

endmodule

/* logic/cop_cprs.sv */
//////////////////////////////
// Coprocessor register file
// Sixteen words, two asynchronous read ports and
// one write port taking effect at the clock edge
//////////////////////////////

module cop_cprs (
    input  logic                    g_clk,
    input  logic                    g_resetn,   // Sync, active low
    cop_cpr_rd_if.regfile           rd_port,    // Two read ports
    input  logic                    crd_wen,    // Write strobe
    input  cop_core_pkg::cpr_addr_t crd_addr,   // Write index
    input  cop_core_pkg::word_t     crd_wdata   // Write data
);

    cop_core_pkg::word_t cprs [cop_core_pkg::CPR_COUNT];  // Register storage

    // All registers start at zero
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < cop_core_pkg::CPR_COUNT; i++) begin
                cprs[i] <= '0;
            end
        end else if (crd_wen) begin
            cprs[crd_addr] <= crd_wdata;  // Visible from next cycle
        end
    end

    // Reads see the value before this cycle's write
    assign rd_port.crs1_rdata = cprs[rd_port.crs1_addr];
    assign rd_port.crs2_rdata = cprs[rd_port.crs2_addr];

endmodule

/* logic/cop_palu.sv */
//////////////////////////////
// Move and bitwise unit, combinational
// One result value feeds both the CPR write data
// and the GPR data of the response
//////////////////////////////

module cop_palu (
    cop_uop_if.alu              uop,      // Decoded operation
    cop_cpr_rd_if.alu           rd_port,  // crs1 and crs2 values
    input  cop_core_pkg::word_t gpr_rs1,  // CPU operand
    output cop_core_pkg::word_t result    // Writeback value
);

    cop_core_pkg::word_t rs1;  // Short names for the sources
    cop_core_pkg::word_t rs2;

    assign rs1 = rd_port.crs1_rdata;
    assign rs2 = rd_port.crs2_rdata;

    always_comb begin
        case (uop.op)
            cop_isa_pkg::OP_GPR2XCR: begin
                result = gpr_rs1;      // Into crd
            end
            cop_isa_pkg::OP_XCR2GPR: begin
                result = rs1;          // Out to rd
            end
            cop_isa_pkg::OP_AND: begin
                result = rs1 & rs2;
            end
            cop_isa_pkg::OP_OR: begin
                result = rs1 | rs2;
            end
            cop_isa_pkg::OP_XOR: begin
                result = rs1 ^ rs2;
            end
            cop_isa_pkg::OP_NOT: begin
                result = ~rs1;         // crs2 unused
            end
            default: begin
                result = '0;           // OP_NONE
            end
        endcase
    end

endmodule

/* logic/cop_issue.sv */
//////////////////////////////
// Issue control and CPU handshake
// Accepts on req & ack, writes the CPR in the accept
// cycle and holds the registered response until retire
//////////////////////////////

module cop_issue (
    input  logic                      g_clk,
    input  logic                      g_resetn,      // Sync, active low
    input  logic                      cpu_insn_req,  // CPU offers an instruction
    input  logic                      cpu_insn_ack,  // CPU takes the response
    output logic                      cop_insn_ack,  // Ready to accept
    output logic                      cop_insn_rsp,  // Response valid
    cop_uop_if.issue                  uop,           // Decoded operation
    input  cop_core_pkg::word_t       alu_result,    // ALU value this cycle
    output logic                      crd_wen,       // CPR write strobe
    output cop_core_pkg::cpr_addr_t   crd_addr,      // CPR write index
    output logic                      cop_wen,       // GPR write enable
    output cop_core_pkg::gpr_addr_t   cop_waddr,     // GPR index
    output cop_core_pkg::word_t       cop_wdata,     // GPR data
    output cop_core_pkg::cop_result_e cop_result     // Result code
);

    cop_core_pkg::issue_state_e state;
    cop_core_pkg::issue_state_e state_nxt;
    logic                       ack_nxt;
    logic                       rsp_nxt;
    logic                       insn_accept;  // Instruction taken this cycle
    logic                       insn_retire;  // Response taken this cycle

    assign insn_accept = cpu_insn_req && cop_insn_ack;
    assign insn_retire = cop_insn_rsp && cpu_insn_ack;

    // Every operation completes in its accept cycle
    assign crd_wen  = insn_accept && uop.writes_cpr;
    assign crd_addr = uop.crd;

    always_comb begin
        state_nxt = cop_core_pkg::ST_IDLE;
        ack_nxt   = 1'b0;
        rsp_nxt   = 1'b0;
        case (state)
            cop_core_pkg::ST_IDLE: begin
                state_nxt = cop_core_pkg::ST_WAITING;  // Raise ack next
                ack_nxt   = 1'b1;
            end
            cop_core_pkg::ST_WAITING: begin
                if (insn_accept) begin
                    state_nxt = cop_core_pkg::ST_FINISHED;
                    rsp_nxt   = 1'b1;
                end else begin
                    state_nxt = cop_core_pkg::ST_WAITING;
                    ack_nxt   = 1'b1;
                end
            end
            cop_core_pkg::ST_FINISHED: begin
                if (insn_retire) begin
                    state_nxt = cop_core_pkg::ST_WAITING;  // Back to ready
                    ack_nxt   = 1'b1;
                end else begin
                    state_nxt = cop_core_pkg::ST_FINISHED;  // Hold the response
                    rsp_nxt   = 1'b1;
                end
            end
            default: begin
                state_nxt = cop_core_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= cop_core_pkg::ST_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
        end else begin
            state        <= state_nxt;
            cop_insn_ack <= ack_nxt;
            cop_insn_rsp <= rsp_nxt;
            if (insn_accept) begin
                cop_wen <= uop.writes_gpr;  // Only XCR2GPR writes a GPR
            end
        end
    end

    // Response payload, loaded at the accept edge only
    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            cop_waddr  <= uop.rd;
            cop_wdata  <= alu_result;
            cop_result <= uop.illegal ? cop_core_pkg::RES_BAD_INS
                                      : cop_core_pkg::RES_SUCCESS;
        end
    end

endmodule

/* logic/cop_top.sv */
//////////////////////////////
// Co-processor top level
// Plain CPU request/response ports; decoder, CPR
// file, ALU and issue control wired together here
//////////////////////////////

module cop_top (
    input  logic                      g_clk,
    input  logic                      g_resetn,      // Sync, active low
    input  logic                      cpu_insn_req,  // Instruction request
    output logic                      cop_insn_ack,  // Request acknowledge
    input  cop_core_pkg::word_t       cpu_insn_enc,  // Instruction word
    input  cop_core_pkg::word_t       cpu_rs1,       // GPR operand
    output logic                      cop_wen,       // GPR write enable
    output cop_core_pkg::gpr_addr_t   cop_waddr,     // GPR write index
    output cop_core_pkg::word_t       cop_wdata,     // GPR write data
    output cop_core_pkg::cop_result_e cop_result,    // Result code
    output logic                      cop_insn_rsp,  // Response valid
    input  logic                      cpu_insn_ack   // Response acknowledge
);

    cop_uop_if    uop ();      // Decoded operation
    cop_cpr_rd_if cpr_rd ();   // CPR read port

    logic                    crd_wen;    // CPR write strobe
    cop_core_pkg::cpr_addr_t crd_addr;   // CPR write index
    cop_core_pkg::word_t     alu_result; // ALU output, CPR and GPR data

    cop_decode u_decode (
        .insn_enc (cpu_insn_enc),
        .uop      (uop),
        .rd_port  (cpr_rd)
    );

    cop_cprs u_cprs (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .rd_port   (cpr_rd),
        .crd_wen   (crd_wen),
        .crd_addr  (crd_addr),
        .crd_wdata (alu_result)
    );

    cop_palu u_palu (
        .uop     (uop),
        .rd_port (cpr_rd),
        .gpr_rs1 (cpu_rs1),
        .result  (alu_result)
    );

    cop_issue u_issue (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .uop          (uop),
        .alu_result   (alu_result),
        .crd_wen      (crd_wen),
        .crd_addr     (crd_addr),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

endmodule

/* test/cop_tb.sv */
//////////////////////////////
// Testbench for the co-processor top level
// Drives instructions over the req/ack handshake,
// predicts responses from a CPR shadow model and
// checks the DUT with concurrent assertions
//////////////////////////////

module cop_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS       = 5;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + RESET_CYCLES;

    logic                      g_clk;
    logic                      g_resetn;
    logic                      cpu_insn_req;
    logic                      cop_insn_ack;
    cop_core_pkg::word_t       cpu_insn_enc;
    cop_core_pkg::word_t       cpu_rs1;
    logic                      cop_wen;
    cop_core_pkg::gpr_addr_t   cop_waddr;
    cop_core_pkg::word_t       cop_wdata;
    cop_core_pkg::cop_result_e cop_result;
    logic                      cop_insn_rsp;
    logic                      cpu_insn_ack;

    cop_core_pkg::word_t       shadow [cop_core_pkg::CPR_COUNT];  // Predicted CPRs
    logic                      exp_wen;                           // Expected response
    cop_core_pkg::gpr_addr_t   exp_waddr;
    cop_core_pkg::word_t       exp_wdata;
    cop_core_pkg::cop_result_e exp_result;
    logic [31:0]               rng = 32'h198cb7f7;                // xorshift state
    int                        errors = 0;
    int                        n_insns = 0;
    int                        tests_done = 0;
    int unsigned               cycle = 0;
    logic                      accept;  // Instruction taken this cycle
    logic                      retire;  // Response taken this cycle

    cop_top UUT (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result),
        .cop_insn_rsp (cop_insn_rsp),
        .cpu_insn_ack (cpu_insn_ack)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;  // 10 ns period
    end

    always @(posedge g_clk) cycle <= cycle + 1;

    assign accept = cpu_insn_req && cop_insn_ack;
    assign retire = cop_insn_rsp && cpu_insn_ack;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("FAIL %s: got %h, expected %h", name, got, want);
    endtask

    task automatic report_violation(input string what);
        errors++;
        $display("Protocol error at %0d ns: %s", $time, what);
    endtask

    // Reset and handshake protocol
    a_reset_quiet: assert property (@(posedge g_clk)
        (!g_resetn && cycle > 0) |-> (!cop_insn_ack && !cop_insn_rsp && !cop_wen))
        else report_violation("ack, rsp or wen high during reset");
    a_ack_low_at_release: assert property (@(posedge g_clk)
        $rose(g_resetn) |-> !cop_insn_ack)
        else report_violation("ack already high on first edge after reset");
    a_ack_rises: assert property (@(posedge g_clk)
        $rose(g_resetn) |=> cop_insn_ack)
        else report_violation("ack not high on second edge after reset");
    a_rsp_after_accept: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accept |=> cop_insn_rsp)
        else report_violation("no response one cycle after accept");
    a_rsp_needs_accept: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (!cop_insn_rsp && !accept) |=> !cop_insn_rsp)
        else report_violation("response rose without an accepted instruction");
    a_ack_rsp_apart: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp |-> !cop_insn_ack)
        else report_violation("ack high while a response is pending");
    a_retire_reopens: assert property (@(posedge g_clk) disable iff (!g_resetn)
        retire |=> (cop_insn_ack && !cop_insn_rsp))
        else report_violation("ack not back or rsp still high after retire");
    a_rsp_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cop_insn_rsp && !cpu_insn_ack) |=> (cop_insn_rsp && !cop_insn_ack
            && $stable(cop_wen) && $stable(cop_waddr)
            && $stable(cop_wdata) && $stable(cop_result)))
        else report_violation("response dropped or changed under back-pressure");

    // Response values against the model
    a_wen: assert property (@(posedge g_clk) cop_insn_rsp |-> cop_wen == exp_wen)
        else report_mismatch("cop_wen", 32'($sampled(cop_wen)), 32'($sampled(exp_wen)));
    a_waddr: assert property (@(posedge g_clk) cop_insn_rsp |-> cop_waddr == exp_waddr)
        else report_mismatch("cop_waddr", 32'($sampled(cop_waddr)),
                             32'($sampled(exp_waddr)));
    a_wdata: assert property (@(posedge g_clk) cop_insn_rsp |-> cop_wdata == exp_wdata)
        else report_mismatch("cop_wdata", $sampled(cop_wdata), $sampled(exp_wdata));
    a_result: assert property (@(posedge g_clk) cop_insn_rsp |-> cop_result == exp_result)
        else report_mismatch("cop_result", 32'($sampled(cop_result)),
                             32'($sampled(exp_result)));

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] encode_insn(input logic [6:0] opcode,
        input logic [3:0] funct, input logic [3:0] crd, input logic [3:0] crs2,
        input logic [3:0] crs1, input logic [4:0] rd);
        return {funct, crd, crs2, crs1, 4'h0, rd, opcode};  // Bits 15..12 unused
    endfunction

    // Expected response and shadow update for one word
    task automatic predict(input logic [31:0] enc, input logic [31:0] rs1);
        logic [3:0]  funct;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic        legal;
        funct = enc[31:28];
        a     = shadow[enc[19:16]];
        b     = shadow[enc[23:20]];
        legal = (enc[6:0] == cop_isa_pkg::COP_OPCODE) && (funct <= 4'd5);
        case (funct)
            4'd0:    value = rs1;     // GPR2XCR
            4'd1:    value = a;       // XCR2GPR
            4'd2:    value = a & b;
            4'd3:    value = a | b;
            4'd4:    value = a ^ b;
            4'd5:    value = ~a;
            default: value = '0;
        endcase
        if (!legal) value = '0;      // Nothing selected
        exp_wen    = legal && (funct == 4'd1);
        exp_waddr  = enc[11:7];
        exp_wdata  = value;
        exp_result = legal ? cop_core_pkg::RES_SUCCESS : cop_core_pkg::RES_BAD_INS;
        if (legal && funct != 4'd1) shadow[enc[27:24]] = value;
    endtask

    // One full request, response and retire exchange
    task automatic run_insn(input logic [31:0] enc, input logic [31:0] rs1, input int hold);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        while (!cop_insn_ack) begin
            @(posedge g_clk);
            #1;
        end
        predict(enc, rs1);           // Accepted at the coming edge
        @(posedge g_clk);
        #1;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = rand_word();  // Junk must not be executed
        cpu_rs1      = rand_word();
        while (!cop_insn_rsp) begin
            @(posedge g_clk);
            #1;
        end
        repeat (hold) begin
            @(posedge g_clk);
            #1;
        end
        cpu_insn_ack = 1'b1;
        @(posedge g_clk);            // Retire edge
        #1;
        cpu_insn_ack = 1'b0;
        n_insns++;
    endtask

    task automatic read_back(input logic [3:0] idx);
        logic [31:0] w;
        w = rand_word();
        run_insn(encode_insn(cop_isa_pkg::COP_OPCODE, cop_isa_pkg::FN_XCR2GPR,
                             w[3:0], w[7:4], idx, w[12:8]), rand_word(), 0);
    endtask

    task automatic close_test(input string name, input int mark);
        @(posedge g_clk);            // Let trailing checks fire
        #1;
        tests_done++;
        $display("test %-12s finished, %0d errors", name, errors - mark);
    endtask

    initial begin
        logic [31:0] w;
        logic [3:0]  funct;
        logic [6:0]  opc;
        int          mark;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_ack = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        for (int i = 0; i < cop_core_pkg::CPR_COUNT; i++) shadow[i] = '0;

        mark = errors;
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        while (!cop_insn_ack) begin
            @(posedge g_clk);
            #1;
        end
        close_test("reset", mark);

        mark = errors;               // Write then read every CPR
        for (int r = 0; r < cop_core_pkg::CPR_COUNT; r++) begin
            w = rand_word();
            run_insn(encode_insn(cop_isa_pkg::COP_OPCODE, cop_isa_pkg::FN_GPR2XCR,
                                 4'(r), w[3:0], w[7:4], w[12:8]), rand_word(), 0);
            read_back(4'(r));
        end
        close_test("moves", mark);

        mark = errors;
        for (int i = 0; i < 24; i++) begin
            w     = rand_word();
            funct = 4'd2 + {2'b00, w[1:0]};  // AND, OR, XOR, NOT
            run_insn(encode_insn(cop_isa_pkg::COP_OPCODE, funct, w[7:4], w[11:8],
                                 w[15:12], w[20:16]), rand_word(), 0);
        end
        for (int r = 0; r < cop_core_pkg::CPR_COUNT; r++) read_back(4'(r));
        close_test("bitwise", mark);

        mark = errors;
        for (int i = 0; i < 10; i++) begin
            w     = rand_word();
            opc   = cop_isa_pkg::COP_OPCODE;
            funct = 4'd6 + (w[31:28] % 4'd10);  // Reserved codes
            if (i % 2 == 0) begin
                opc   = w[6:0];
                if (opc == cop_isa_pkg::COP_OPCODE) opc = opc ^ 7'h40;
                funct = {1'b0, w[30:28]};     // Bad opcode hides any function
            end
            run_insn(encode_insn(opc, funct, w[11:8], w[15:12], w[19:16], w[24:20]),
                     rand_word(), 0);
            read_back(w[11:8]);               // crd must be unchanged
        end
        close_test("illegal", mark);

        mark = errors;
        for (int i = 0; i < 16; i++) begin
            w     = rand_word();
            funct = {1'b0, w[2:0] % 3'd6};
            run_insn(encode_insn(cop_isa_pkg::COP_OPCODE, funct, w[15:12], w[19:16],
                                 w[23:20], w[28:24]), rand_word(), int'(w[10:8]));
        end
        close_test("backpressure", mark);

        $display("tests %0d, instructions %0d, errors %0d", tests_done, n_insns, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge g_clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* flist.f */
logic/cop_isa_pkg.sv
logic/cop_core_pkg.sv
logic/cop_ifs.sv
logic/cop_decode.sv
logic/cop_cprs.sv
logic/cop_palu.sv
logic/cop_issue.sv
logic/cop_top.sv
test/cop_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the co-processor testbench with Verilator.
# A crashed simulation counts as a failure as well.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cop_tb -f flist.f || exit 1
./obj_dir/Vcop_tb > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && echo "Simulation failed" && exit 1 || echo "Simulation passed"
